//--- compile.f
+incdir+src
src/tlb_pkg.sv
src/tlb_ctrl.sv
src/tlb_page_array.sv
src/tlb_superpage_array.sv
src/tlb_resp_gen.sv
src/tlb_top.sv
verif/tb_tlb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tlb \
  -f compile.f -o tb_tlb_sim

out=$(./obj_dir/tb_tlb_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- src/tlb_consts.svh
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// address and page geometry, Sv39
`define TLB_VADDR_W      39
`define TLB_PADDR_W      40
`define TLB_PG_IDX_W     12
`define TLB_VPN_FIELD_W  9
`define TLB_PG_LEVELS    3
`define TLB_PPN_W        28

// entry counts
`define TLB_NORMAL_NUM   8
`define TLB_SUPER_NUM    4

// csr layout
`define TLB_XLEN         64
`define TLB_STATUS_SUM   18
`define TLB_STATUS_MXR   19

`endif

//--- src/tlb_ctrl.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tlb_ctrl import tlb_pkg::*; (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_req_valid,
  input  vpn_t                       i_req_vpn,
  input  logic                       i_lookup_miss,
  input  logic                       i_kill,
  input  logic                       i_sfence,
  input  logic                       i_ptw_req_ready,
  input  logic                       i_ptw_resp_valid,
  input  xlen_t                      i_ptw_resp_pte,
  input  level_t                     i_ptw_resp_level,
  input  logic [`TLB_NORMAL_NUM-1:0] i_normal_valids,
  input  logic [`TLB_SUPER_NUM-1:0]  i_super_valids,
  output logic                       o_ready,
  output logic                       o_ptw_req_valid,
  output vpn_t                       o_ptw_req_vpn,
  output logic                       o_fill_normal,
  output logic                       o_fill_super,
  output logic [`TLB_NORMAL_NUM-1:0] o_fill_slot_normal,
  output logic [`TLB_SUPER_NUM-1:0]  o_fill_slot_super,
  output vpn_t                       o_fill_vpn,
  output ppn_t                       o_fill_ppn,
  output level_t                     o_fill_level,
  output tlb_flags_t                 o_fill_flags,
  output logic                       o_tlb_update
);

  refill_state_t r_state;
  vpn_t          r_refill_tag;
  logic          w_start;
  logic          w_do_fill;
  logic          w_leaf;
  logic [`TLB_NORMAL_NUM-1:0] w_free_normal;
  logic [`TLB_SUPER_NUM-1:0]  w_free_super;

  // ----------------------------------------------------------------------
  // refill FSM
  // ----------------------------------------------------------------------
  assign w_start   = (r_state == ST_READY) && i_req_valid && i_lookup_miss;
  assign w_do_fill = (r_state == ST_WAIT) && i_ptw_resp_valid && !i_sfence;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= ST_READY;
      o_tlb_update <= 1'b0;
    end else begin
      o_tlb_update <= w_do_fill;
      case (r_state)
        ST_READY: begin
          if (w_start) begin
            r_state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (i_kill) begin
            r_state <= ST_READY;
          end else if (i_ptw_req_ready) begin
            r_state <= i_sfence ? ST_WAIT_INVALIDATE : ST_WAIT;
          end else if (i_sfence) begin
            r_state <= ST_READY;
          end
        end
        ST_WAIT: begin
          if (i_ptw_resp_valid) begin
            r_state <= ST_READY; // walk over either way
          end else if (i_sfence) begin
            r_state <= ST_WAIT_INVALIDATE;
          end
        end
        default: begin
          if (i_ptw_resp_valid) begin
            r_state <= ST_READY;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_refill_tag <= i_req_vpn;
    end
  end

  assign o_ready         = (r_state == ST_READY);
  assign o_ptw_req_valid = (r_state == ST_REQUEST);
  assign o_ptw_req_vpn   = r_refill_tag;

  // ----------------------------------------------------------------------
  // fill data
  // ----------------------------------------------------------------------
  // pte bit order from bit 0 is v r w x u g a d
  assign w_leaf = i_ptw_resp_pte[0] & i_ptw_resp_pte[6] &
                  (i_ptw_resp_pte[1] | (i_ptw_resp_pte[3] & ~i_ptw_resp_pte[2]));

  assign o_fill_flags.u  = i_ptw_resp_pte[4];
  assign o_fill_flags.sr = w_leaf & i_ptw_resp_pte[1];
  assign o_fill_flags.sw = w_leaf & i_ptw_resp_pte[2] & i_ptw_resp_pte[7];
  assign o_fill_flags.sx = w_leaf & i_ptw_resp_pte[3];

  assign o_fill_vpn   = r_refill_tag;
  assign o_fill_ppn   = i_ptw_resp_pte[10 +: `TLB_PPN_W];
  assign o_fill_level = i_ptw_resp_level;

  assign o_fill_normal = w_do_fill && (i_ptw_resp_level == `TLB_PG_LEVELS - 1);
  assign o_fill_super  = w_do_fill && (i_ptw_resp_level < `TLB_PG_LEVELS - 1);

  // lowest free entry or entry 0 when full
  assign w_free_normal      = ~i_normal_valids & (i_normal_valids + 1'b1);
  assign w_free_super       = ~i_super_valids & (i_super_valids + 1'b1);
  assign o_fill_slot_normal = (w_free_normal == '0) ?
                              {{(`TLB_NORMAL_NUM-1){1'b0}}, 1'b1} : w_free_normal;
  assign o_fill_slot_super  = (w_free_super == '0) ?
                              {{(`TLB_SUPER_NUM-1){1'b0}}, 1'b1} : w_free_super;

  a_one_fill: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_fill_normal && o_fill_super));

  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ptw_req_valid && !i_ptw_req_ready && !i_kill && !i_sfence |=>
      o_ptw_req_valid && $stable(o_ptw_req_vpn));

endmodule

//--- src/tlb_page_array.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tlb_page_array import tlb_pkg::*; #(
  parameter int NUM_ENTRIES = `TLB_NORMAL_NUM
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  vpn_t                   i_lookup_vpn,
  input  logic                   i_flush,
  input  logic                   i_fill,
  input  logic [NUM_ENTRIES-1:0] i_fill_slot,
  input  vpn_t                   i_fill_vpn,
  input  ppn_t                   i_fill_ppn,
  input  tlb_flags_t             i_fill_flags,
  output logic                   o_hit,
  output ppn_t                   o_hit_ppn,
  output tlb_flags_t             o_hit_flags,
  output logic [NUM_ENTRIES-1:0] o_valids
);

  logic [NUM_ENTRIES-1:0] r_valid;
  vpn_t                   r_tag   [NUM_ENTRIES];
  ppn_t                   r_ppn   [NUM_ENTRIES];
  tlb_flags_t             r_flags [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] w_hit_vec;

  // fill beats flush on the written entry
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (i_fill && i_fill_slot[i]) begin
          r_valid[i] <= 1'b1;
        end else if (i_flush) begin
          r_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (i_fill && i_fill_slot[i]) begin
        r_tag[i]   <= i_fill_vpn;
        r_ppn[i]   <= i_fill_ppn;
        r_flags[i] <= i_fill_flags;
      end
    end
  end

  // full tag compare, one-hot or-select
  always_comb begin
    o_hit_ppn   = '0;
    o_hit_flags = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      w_hit_vec[i] = r_valid[i] && (r_tag[i] == i_lookup_vpn);
      if (w_hit_vec[i]) begin
        o_hit_ppn   = o_hit_ppn | r_ppn[i];
        o_hit_flags = o_hit_flags | r_flags[i];
      end
    end
  end

  assign o_hit    = |w_hit_vec;
  assign o_valids = r_valid;

  a_single_hit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_hit_vec));

endmodule

//--- src/tlb_pkg.sv
`include "tlb_consts.svh"

package tlb_pkg;

  typedef logic [`TLB_VADDR_W-1:0] vaddr_t;
  typedef logic [`TLB_PADDR_W-1:0] paddr_t;
  typedef logic [`TLB_VPN_FIELD_W*`TLB_PG_LEVELS-1:0] vpn_t;
  typedef logic [`TLB_PPN_W-1:0] ppn_t;

  // walk level, 2 is a 4 KiB leaf, 0 is a 1 GiB leaf
  typedef logic [1:0] level_t;

  // U=0, S=1, M=3
  typedef logic [1:0] priv_t;

  typedef logic [`TLB_XLEN-1:0] xlen_t;

  // decoded leaf permissions
  typedef struct packed {
    logic u;
    logic sr;
    logic sw;
    logic sx;
  } tlb_flags_t;

  typedef enum logic [1:0] {
    ST_READY           = 2'd0,
    ST_REQUEST         = 2'd1,
    ST_WAIT            = 2'd2,
    ST_WAIT_INVALIDATE = 2'd3
  } refill_state_t;

endpackage

//--- src/tlb_resp_gen.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tlb_resp_gen import tlb_pkg::*; (
  input  logic       i_req_valid,
  input  vaddr_t     i_req_vaddr,
  input  logic [1:0] i_req_cmd,   // 0 read, 1 write, 2 fetch
  input  logic       i_req_passthrough,
  input  priv_t      i_priv,
  input  xlen_t      i_csr_satp,
  input  xlen_t      i_csr_status,
  input  logic       i_page_hit,
  input  ppn_t       i_page_ppn,
  input  tlb_flags_t i_page_flags,
  input  logic       i_super_hit,
  input  ppn_t       i_super_ppn,
  input  tlb_flags_t i_super_flags,
  input  logic       i_fill_strobe,
  output logic       o_lookup_miss,
  output logic       o_resp_miss,
  output paddr_t     o_resp_paddr,
  output logic       o_pf_ld,
  output logic       o_pf_st,
  output logic       o_pf_inst
);

  logic       w_vm_en;
  logic       w_hit;
  logic       w_check;
  logic       w_priv_s;
  logic       w_rw_ok;
  logic       w_x_ok;
  logic       w_sum;
  logic       w_mxr;
  ppn_t       w_ppn;
  tlb_flags_t w_flags;

  assign w_vm_en = (i_csr_satp[`TLB_XLEN-1 -: 2] != 2'b00) && (i_priv <= 2'd1) &&
                   !i_req_passthrough;

  assign w_hit   = i_page_hit | i_super_hit;
  assign w_ppn   = i_page_hit ? i_page_ppn : i_super_ppn;
  assign w_flags = i_page_hit ? i_page_flags : i_super_flags;

  assign o_lookup_miss = i_req_valid && w_vm_en && !w_hit;
  assign o_resp_miss   = o_lookup_miss || i_fill_strobe;
  assign o_resp_paddr  = w_vm_en ? {w_ppn, i_req_vaddr[`TLB_PG_IDX_W-1:0]} :
                         {{(`TLB_PADDR_W - `TLB_VADDR_W){1'b0}}, i_req_vaddr};

  // permission checks
  assign w_sum    = i_csr_status[`TLB_STATUS_SUM];
  assign w_mxr    = i_csr_status[`TLB_STATUS_MXR];
  assign w_priv_s = (i_priv == 2'd1);
  assign w_rw_ok  = w_priv_s ? (!w_flags.u || w_sum) : w_flags.u;
  assign w_x_ok   = w_priv_s ? !w_flags.u : w_flags.u;
  assign w_check  = w_vm_en && w_hit;

  assign o_pf_ld   = w_check && (i_req_cmd == 2'd0) &&
                     !(w_rw_ok && (w_flags.sr || (w_flags.sx && w_mxr)));
  assign o_pf_st   = w_check && (i_req_cmd == 2'd1) && !(w_rw_ok && w_flags.sw);
  assign o_pf_inst = w_check && (i_req_cmd == 2'd2) && !(w_x_ok && w_flags.sx);

endmodule

//--- src/tlb_superpage_array.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tlb_superpage_array import tlb_pkg::*; #(
  parameter int NUM_ENTRIES = `TLB_SUPER_NUM
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  vpn_t                   i_lookup_vpn,
  input  logic                   i_flush,
  input  logic                   i_fill,
  input  logic [NUM_ENTRIES-1:0] i_fill_slot,
  input  vpn_t                   i_fill_vpn,
  input  ppn_t                   i_fill_ppn,
  input  level_t                 i_fill_level,
  input  tlb_flags_t             i_fill_flags,
  output logic                   o_hit,
  output ppn_t                   o_hit_ppn,
  output tlb_flags_t             o_hit_flags,
  output logic [NUM_ENTRIES-1:0] o_valids
);

  logic [NUM_ENTRIES-1:0] r_valid;
  vpn_t                   r_tag   [NUM_ENTRIES];
  ppn_t                   r_ppn   [NUM_ENTRIES];
  level_t                 r_level [NUM_ENTRIES];
  tlb_flags_t             r_flags [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] w_hit_vec;
  ppn_t                   w_entry_ppn [NUM_ENTRIES];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (i_fill && i_fill_slot[i]) begin
          r_valid[i] <= 1'b1;
        end else if (i_flush) begin
          r_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (i_fill && i_fill_slot[i]) begin
        r_tag[i]   <= i_fill_vpn;
        r_ppn[i]   <= i_fill_ppn;
        r_level[i] <= i_fill_level;
        r_flags[i] <= i_fill_flags;
      end
    end
  end

  // ----------------------------------------------------------------------
  // level-aware match, fields below the leaf come from the lookup vpn
  // ----------------------------------------------------------------------
  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    logic [`TLB_PG_LEVELS-1:0] w_field_match;

    for (genvar lvl = 0; lvl < `TLB_PG_LEVELS; lvl++) begin : g_lvl
      localparam int BASE = (`TLB_PG_LEVELS - 1 - lvl) * `TLB_VPN_FIELD_W;
      logic w_ignore;

      assign w_ignore = (lvl > r_level[e]);
      assign w_field_match[lvl] = w_ignore ||
        (r_tag[e][BASE +: `TLB_VPN_FIELD_W] == i_lookup_vpn[BASE +: `TLB_VPN_FIELD_W]);
      assign w_entry_ppn[e][BASE +: `TLB_VPN_FIELD_W] = w_ignore ?
        i_lookup_vpn[BASE +: `TLB_VPN_FIELD_W] : r_ppn[e][BASE +: `TLB_VPN_FIELD_W];
    end

    // ppn msb sits above the vpn fields
    assign w_entry_ppn[e][`TLB_PPN_W-1] = r_ppn[e][`TLB_PPN_W-1];
    assign w_hit_vec[e] = r_valid[e] && (&w_field_match);

    a_level: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      r_valid[e] |-> r_level[e] < `TLB_PG_LEVELS - 1);
  end

  always_comb begin
    o_hit_ppn   = '0;
    o_hit_flags = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_hit_vec[i]) begin
        o_hit_ppn   = o_hit_ppn | w_entry_ppn[i];
        o_hit_flags = o_hit_flags | r_flags[i];
      end
    end
  end

  assign o_hit    = |w_hit_vec;
  assign o_valids = r_valid;

endmodule

//--- src/tlb_top.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tlb_top import tlb_pkg::*; (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_req_valid,
  input  vaddr_t     i_req_vaddr,
  input  logic [1:0] i_req_cmd,
  input  logic       i_req_passthrough,
  input  logic       i_kill,
  input  logic       i_sfence,
  input  priv_t      i_priv,
  input  xlen_t      i_csr_satp,
  input  xlen_t      i_csr_status,
  output logic       o_ready,
  output logic       o_resp_miss,
  output paddr_t     o_resp_paddr,
  output logic       o_pf_ld,
  output logic       o_pf_st,
  output logic       o_pf_inst,
  // walker
  output logic       o_ptw_req_valid,
  input  logic       i_ptw_req_ready,
  output vpn_t       o_ptw_req_vpn,
  input  logic       i_ptw_resp_valid,
  input  xlen_t      i_ptw_resp_pte,
  input  level_t     i_ptw_resp_level,
  output xlen_t      o_ptw_status,
  output logic       o_tlb_update
);

  vpn_t       w_req_vpn;
  logic       w_lookup_miss;
  logic       w_fill_normal;
  logic       w_fill_super;
  logic [`TLB_NORMAL_NUM-1:0] w_slot_normal;
  logic [`TLB_SUPER_NUM-1:0]  w_slot_super;
  logic [`TLB_NORMAL_NUM-1:0] w_normal_valids;
  logic [`TLB_SUPER_NUM-1:0]  w_super_valids;
  vpn_t       w_fill_vpn;
  ppn_t       w_fill_ppn;
  level_t     w_fill_level;
  tlb_flags_t w_fill_flags;
  logic       w_page_hit;
  ppn_t       w_page_ppn;
  tlb_flags_t w_page_flags;
  logic       w_super_hit;
  ppn_t       w_super_ppn;
  tlb_flags_t w_super_flags;

  assign w_req_vpn    = i_req_vaddr[`TLB_VADDR_W-1:`TLB_PG_IDX_W];
  assign o_ptw_status = i_csr_status;

  tlb_ctrl u_ctrl (
    .i_clk, .i_reset_n, .i_req_valid,
    .i_req_vpn          (w_req_vpn),
    .i_lookup_miss      (w_lookup_miss),
    .i_kill, .i_sfence, .i_ptw_req_ready, .i_ptw_resp_valid,
    .i_ptw_resp_pte, .i_ptw_resp_level,
    .i_normal_valids    (w_normal_valids),
    .i_super_valids     (w_super_valids),
    .o_ready, .o_ptw_req_valid, .o_ptw_req_vpn,
    .o_fill_normal      (w_fill_normal),
    .o_fill_super       (w_fill_super),
    .o_fill_slot_normal (w_slot_normal),
    .o_fill_slot_super  (w_slot_super),
    .o_fill_vpn         (w_fill_vpn),
    .o_fill_ppn         (w_fill_ppn),
    .o_fill_level       (w_fill_level),
    .o_fill_flags       (w_fill_flags),
    .o_tlb_update
  );

  tlb_page_array #(.NUM_ENTRIES(`TLB_NORMAL_NUM)) u_page (
    .i_clk, .i_reset_n,
    .i_lookup_vpn (w_req_vpn),
    .i_flush      (i_sfence),
    .i_fill       (w_fill_normal),
    .i_fill_slot  (w_slot_normal),
    .i_fill_vpn   (w_fill_vpn),
    .i_fill_ppn   (w_fill_ppn),
    .i_fill_flags (w_fill_flags),
    .o_hit        (w_page_hit),
    .o_hit_ppn    (w_page_ppn),
    .o_hit_flags  (w_page_flags),
    .o_valids     (w_normal_valids)
  );

  tlb_superpage_array #(.NUM_ENTRIES(`TLB_SUPER_NUM)) u_super (
    .i_clk, .i_reset_n,
    .i_lookup_vpn (w_req_vpn),
    .i_flush      (i_sfence),
    .i_fill       (w_fill_super),
    .i_fill_slot  (w_slot_super),
    .i_fill_vpn   (w_fill_vpn),
    .i_fill_ppn   (w_fill_ppn),
    .i_fill_level (w_fill_level),
    .i_fill_flags (w_fill_flags),
    .o_hit        (w_super_hit),
    .o_hit_ppn    (w_super_ppn),
    .o_hit_flags  (w_super_flags),
    .o_valids     (w_super_valids)
  );

  tlb_resp_gen u_resp (
    .i_req_valid, .i_req_vaddr, .i_req_cmd, .i_req_passthrough,
    .i_priv, .i_csr_satp, .i_csr_status,
    .i_page_hit    (w_page_hit),
    .i_page_ppn    (w_page_ppn),
    .i_page_flags  (w_page_flags),
    .i_super_hit   (w_super_hit),
    .i_super_ppn   (w_super_ppn),
    .i_super_flags (w_super_flags),
    .i_fill_strobe (w_fill_normal | w_fill_super),
    .o_lookup_miss (w_lookup_miss),
    .o_resp_miss, .o_resp_paddr, .o_pf_ld, .o_pf_st, .o_pf_inst
  );

endmodule

//--- verif/tb_tlb.sv
`timescale 1ns/1ps
`include "tlb_consts.svh"

module tb_tlb import tlb_pkg::*; ();

  localparam int CLK_HALF = 20;
  localparam int MAX_VEC  = 64;

  logic       i_clk = 1'b0;
  logic       i_reset_n;
  logic       i_req_valid;
  vaddr_t     i_req_vaddr;
  logic [1:0] i_req_cmd;
  logic       i_req_passthrough;
  logic       i_kill;
  logic       i_sfence;
  priv_t      i_priv;
  xlen_t      i_csr_satp;
  xlen_t      i_csr_status;
  logic       i_ptw_req_ready;
  logic       i_ptw_resp_valid;
  xlen_t      i_ptw_resp_pte;
  level_t     i_ptw_resp_level;
  logic       o_ready;
  logic       o_resp_miss;
  paddr_t     o_resp_paddr;
  logic       o_pf_ld;
  logic       o_pf_st;
  logic       o_pf_inst;
  logic       o_ptw_req_valid;
  vpn_t       o_ptw_req_vpn;
  xlen_t      o_ptw_status;
  logic       o_tlb_update;

  // vector table with one entry per file line
  logic [8*24-1:0] v_name   [MAX_VEC];
  logic [8*8-1:0]  v_op     [MAX_VEC];
  vaddr_t          v_vaddr  [MAX_VEC];
  priv_t           v_priv   [MAX_VEC];
  logic [3:0]      v_mode   [MAX_VEC];
  logic            v_pt     [MAX_VEC];
  xlen_t           v_status [MAX_VEC];
  logic [1:0]      v_cmd    [MAX_VEC];
  xlen_t           v_pte    [MAX_VEC];
  level_t          v_level  [MAX_VEC];
  paddr_t          v_paddr  [MAX_VEC];
  logic            v_miss   [MAX_VEC];
  logic [2:0]      v_pf     [MAX_VEC]; // ld, st, inst

  integer n_vec  = 0;
  integer n_err  = 0;
  integer n_pass = 0;
  integer n_fail = 0;
  integer seed   = 72014;
  integer accept_delay;
  integer resp_delay;
  logic   walker_hold = 1'b0;
  xlen_t  cur_pte;
  level_t cur_level;

  tlb_top u_dut (
    .i_clk, .i_reset_n, .i_req_valid, .i_req_vaddr, .i_req_cmd, .i_req_passthrough,
    .i_kill, .i_sfence, .i_priv, .i_csr_satp, .i_csr_status,
    .o_ready, .o_resp_miss, .o_resp_paddr, .o_pf_ld, .o_pf_st, .o_pf_inst,
    .o_ptw_req_valid, .i_ptw_req_ready, .o_ptw_req_vpn,
    .i_ptw_resp_valid, .i_ptw_resp_pte, .i_ptw_resp_level,
    .o_ptw_status, .o_tlb_update
  );

  always #(CLK_HALF) i_clk = ~i_clk;

  // ----------------------------------------------------------------------
  // page-table walker model
  // ----------------------------------------------------------------------
  always begin
    @(negedge i_clk);
    if (o_ptw_req_valid === 1'b1 && !walker_hold) begin
      accept_delay = $unsigned($random(seed)) % 4;
      repeat (accept_delay) @(posedge i_clk); // back-pressure
      @(posedge i_clk);
      #2;
      i_ptw_req_ready = 1'b1;
      @(posedge i_clk);
      #2;
      i_ptw_req_ready = 1'b0;
      resp_delay = $unsigned($random(seed)) % 4;
      repeat (resp_delay) @(posedge i_clk);
      @(posedge i_clk);
      #2;
      i_ptw_resp_pte   = cur_pte;
      i_ptw_resp_level = cur_level;
      i_ptw_resp_valid = 1'b1;
      @(posedge i_clk);
      #2;
      i_ptw_resp_valid = 1'b0;
    end
  end

  task automatic load_vectors();
    integer fd;
    integer cnt;
    logic [8*200-1:0] line;
    logic [63:0] ld;
    logic [63:0] st;
    logic [63:0] inst;
    fd = $fopen("verif/tlb_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file verif/tlb_vectors.txt");
      n_err = n_err + 1;
    end else begin
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_name[n_vec], v_op[n_vec], v_vaddr[n_vec], v_priv[n_vec],
                        v_mode[n_vec], v_pt[n_vec], v_status[n_vec], v_cmd[n_vec],
                        v_pte[n_vec], v_level[n_vec], v_paddr[n_vec], v_miss[n_vec],
                        ld, st, inst);
          if (cnt == 15) begin // comment lines fall short
            v_pf[n_vec] = {ld[0], st[0], inst[0]};
            n_vec = n_vec + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_mismatch(input integer idx, input logic [8*10-1:0] what,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("Fail %0s %0s expected %h actual %h", v_name[idx], what, exp, act);
    n_err = n_err + 1;
  endtask

  task automatic report_problem(input integer idx, input logic [8*48-1:0] msg);
    $display("%0s: %0s", v_name[idx], msg);
    n_err = n_err + 1;
  endtask

  task automatic wait_ready();
    @(negedge i_clk);
    while (o_ready !== 1'b1) @(negedge i_clk);
  endtask

  // one request cycle with outputs sampled mid-cycle
  task automatic send_lookup(output logic miss, output paddr_t paddr, output logic [2:0] pf);
    wait_ready();
    @(posedge i_clk);
    #2;
    i_req_valid = 1'b1;
    @(negedge i_clk);
    miss  = o_resp_miss;
    paddr = o_resp_paddr;
    pf    = {o_pf_ld, o_pf_st, o_pf_inst};
    @(posedge i_clk);
    #2;
    i_req_valid = 1'b0;
  endtask

  task automatic lookup_test(input integer idx);
    logic       miss;
    paddr_t     paddr;
    logic [2:0] pf;
    send_lookup(miss, paddr, pf);
    if (miss !== v_miss[idx]) report_mismatch(idx, "miss", v_miss[idx], miss);
    if (o_ptw_status !== v_status[idx])
      report_mismatch(idx, "ptw_status", v_status[idx], o_ptw_status);
    if (miss === 1'b1) begin
      @(negedge i_clk);
      if (o_ptw_req_valid !== 1'b1) report_problem(idx, "no walker request after a miss");
      if (o_ptw_req_vpn !== v_vaddr[idx][`TLB_VADDR_W-1:`TLB_PG_IDX_W])
        report_mismatch(idx, "ptw_vpn", v_vaddr[idx][`TLB_VADDR_W-1:`TLB_PG_IDX_W],
                        o_ptw_req_vpn);
      while (o_tlb_update !== 1'b1) @(negedge i_clk);
      send_lookup(miss, paddr, pf);
      if (miss !== 1'b0) report_problem(idx, "lookup still misses after the refill");
    end
    if (paddr !== v_paddr[idx]) report_mismatch(idx, "paddr", v_paddr[idx], paddr);
    if (pf !== v_pf[idx]) report_mismatch(idx, "faults", v_pf[idx], pf);
  endtask

  task automatic kill_walk(input integer idx);
    logic       miss;
    paddr_t     paddr;
    logic [2:0] pf;
    walker_hold = 1'b1; // walker ignores the request until the kill
    send_lookup(miss, paddr, pf);
    if (miss !== v_miss[idx]) report_mismatch(idx, "miss", v_miss[idx], miss);
    @(negedge i_clk);
    if (o_ptw_req_valid !== 1'b1) report_problem(idx, "no walker request to kill");
    @(posedge i_clk);
    #2;
    i_kill = 1'b1;
    @(posedge i_clk);
    #2;
    i_kill = 1'b0;
    walker_hold = 1'b0; // a request still pending would now complete
    repeat (16) begin
      @(negedge i_clk);
      if (o_tlb_update !== 1'b0) report_problem(idx, "tlb update after a killed walk");
    end
    if (o_ready !== 1'b1) report_problem(idx, "not ready after the kill");
  endtask

  task automatic pulse_sfence();
    wait_ready();
    @(posedge i_clk);
    #2;
    i_sfence = 1'b1;
    @(posedge i_clk);
    #2;
    i_sfence = 1'b0;
  endtask

  task automatic run_test(input integer idx);
    integer err_before;
    err_before = n_err;
    @(posedge i_clk);
    #2;
    i_req_vaddr       = v_vaddr[idx];
    i_priv            = v_priv[idx];
    i_csr_satp        = {v_mode[idx], 60'd0};
    i_req_passthrough = v_pt[idx];
    i_csr_status      = v_status[idx];
    i_req_cmd         = v_cmd[idx];
    cur_pte           = v_pte[idx];
    cur_level         = v_level[idx];
    if (v_op[idx] == "look") lookup_test(idx);
    else if (v_op[idx] == "sfence") pulse_sfence();
    else if (v_op[idx] == "kill") kill_walk(idx);
    else report_problem(idx, "unknown operation in the vector file");
    if (n_err == err_before) begin
      n_pass = n_pass + 1;
      $display("%0s passed", v_name[idx]);
    end else begin
      n_fail = n_fail + 1;
      $display("%0s failed", v_name[idx]);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    i_reset_n         = 1'b0;
    i_req_valid       = 1'b0;
    i_req_vaddr       = '0;
    i_req_cmd         = 2'd0;
    i_req_passthrough = 1'b0;
    i_kill            = 1'b0;
    i_sfence          = 1'b0;
    i_priv            = 2'd1;
    i_csr_satp        = '0;
    i_csr_status      = '0;
    i_ptw_req_ready   = 1'b0;
    i_ptw_resp_valid  = 1'b0;
    i_ptw_resp_pte    = '0;
    i_ptw_resp_level  = 2'd0;
    load_vectors();
    repeat (5) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;
    @(negedge i_clk);
    if (o_ready !== 1'b1 || o_ptw_req_valid !== 1'b0 || o_tlb_update !== 1'b0) begin
      $display("reset: outputs are not idle after reset");
      n_err = n_err + 1;
    end
    for (int i = 0; i < n_vec; i++) begin
      run_test(i);
    end
    $display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog allows 200 cycles per vector line
  initial begin
    #1;
    repeat ((n_vec + 1) * 200) @(posedge i_clk);
    $display("watchdog: the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verif/tlb_vectors.txt
# name op vaddr priv satp_mode pt status cmd | walker pte level | paddr miss pf_ld pf_st pf_inst
# all numbers hex, op is look, sfence or kill, miss is for the first lookup
bare_mode0       look   7fdeadbeef 1 0 0 0     0 0          0 7fdeadbeef 0 0 0 0
bare_mach        look   0040001234 3 8 0 0     1 0          0 0040001234 0 0 0 0
bare_pass        look   1234567abc 1 8 1 0     2 0          0 1234567abc 0 0 0 0
page_miss        look   0000401123 1 8 0 0     0 20048cc7   2 0080123123 1 0 0 0
page_hit         look   0000401ff8 1 8 0 0     1 0          0 0080123ff8 0 0 0 0
mega_miss        look   0040a33456 1 8 0 0     2 303800cf   1 00c0e33456 1 0 0 0
mega_hit         look   0040bf0008 1 8 0 0     0 0          0 00c0ff0008 0 0 0 0
giga_miss        look   00b56cd010 1 8 0 0     0 20500000c7 0 81756cd010 1 0 0 0
giga_hit         look   0080202abc 1 8 0 0     1 0          0 8140202abc 0 0 0 0
user_from_s      look   0000601010 1 8 0 0     0 800d7      2 0000200010 1 1 0 0
user_with_sum    look   0000601010 1 8 0 40000 0 0          0 0000200010 0 0 0 0
user_from_u      look   0000601010 0 8 0 0     1 0          0 0000200010 0 0 0 0
store_no_d       look   0000602020 1 8 0 0     1 80447      2 0000201020 1 0 1 0
store_no_w       look   0000603030 1 8 0 0     1 808c3      2 0000202030 1 0 1 0
fetch_no_x       look   0000603034 1 8 0 0     2 0          0 0000202034 0 0 0 1
xonly_load       look   0000604040 1 8 0 0     0 80c49      2 0000203040 1 1 0 0
xonly_load_mxr   look   0000604040 1 8 0 80000 0 0          0 0000203040 0 0 0 0
sfence_all       sfence 0000000000 1 8 0 0     0 0          0 0000000000 0 0 0 0
page_after_sf    look   0000401123 1 8 0 0     0 20048cc7   2 0080123123 1 0 0 0
mega_after_sf    look   0040bf0008 1 8 0 0     0 303800cf   1 00c0ff0008 1 0 0 0
kill_walk        kill   0000605000 1 8 0 0     0 0          0 0000000000 1 0 0 0
page_after_kill  look   0000605008 1 8 0 0     0 810c7      2 0000204008 1 0 0 0
fill_606         look   0000606000 1 8 0 0     0 c18c7      2 0000306000 1 0 0 0
fill_607         look   0000607000 1 8 0 0     0 c1cc7      2 0000307000 1 0 0 0
fill_608         look   0000608000 1 8 0 0     0 c20c7      2 0000308000 1 0 0 0
fill_609         look   0000609000 1 8 0 0     0 c24c7      2 0000309000 1 0 0 0
fill_60a         look   000060a000 1 8 0 0     0 c28c7      2 000030a000 1 0 0 0
fill_60b         look   000060b000 1 8 0 0     0 c2cc7      2 000030b000 1 0 0 0
fill_ninth       look   000060c000 1 8 0 0     0 c30c7      2 000030c000 1 0 0 0
repl_evicted     look   0000401123 1 8 0 0     0 20048cc7   2 0080123123 1 0 0 0
repl_kept        look   0000605008 1 8 0 0     0 0          0 0000204008 0 0 0 0
